// File: spi_cmd_ctrl.f
spi_cmd_pkg.sv
spi_xfer_if.sv
spi_cmd_decode.sv
spi_byte_engine.sv
spi_rsp_collect.sv
spi_cmd_ctrl.sv
tb_spi_slave.sv
tb_spi_cmd_ctrl.sv

// File: tb_spi_cmd_ctrl.sv
`timescale 1ns/1ps

module tb_spi_cmd_ctrl;

	localparam int CLK_PERIOD = 40;
	localparam int N_CS = 8;
	localparam int N_XFER = 24;
	localparam int XFER_LIMIT = 4 + 16 * 4 + 16; // slowest divider plus slack
	localparam int RUN_CYCLES = 20 + N_CS * 4 + N_XFER * (XFER_LIMIT + 16) + 100;

	logic clk = 1'b0;
	logic rst_n;
	logic cmd_valid;
	logic [spi_cmd_pkg::CMD_W-1:0] cmd;
	logic busy;
	logic rsp_valid;
	logic [7:0] rsp_data;
	logic [7:0] xfer_count;
	logic [7:0] drop_count;
	logic cs_n;
	logic dclk;
	logic mosi;
	logic miso;
	logic slave_load;
	logic [7:0] slave_byte;
	logic [7:0] slave_rx;

	integer seed;
	int err_cnt;
	int test_errs;
	int pass_cnt;
	int fail_cnt;

	// reference model state
	logic model_cs_n;
	int model_div;
	int model_xfers;
	int model_drops;

	spi_cmd_ctrl #(
		.DIV_W(16),
		.CNT_W(8)
	) uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_cmd_valid (cmd_valid),
		.i_cmd       (cmd),
		.o_busy      (busy),
		.o_rsp_valid (rsp_valid),
		.o_rsp_data  (rsp_data),
		.o_xfer_count(xfer_count),
		.o_drop_count(drop_count),
		.o_spi_cs_n  (cs_n),
		.o_spi_dclk  (dclk),
		.o_spi_mosi  (mosi),
		.i_spi_miso  (miso)
	);

	tb_spi_slave slave (
		.i_dclk     (dclk),
		.i_mosi     (mosi),
		.i_load     (slave_load),
		.i_load_byte(slave_byte),
		.o_miso     (miso),
		.o_rx_byte  (slave_rx)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name);
		if (err_cnt == test_errs) begin
			pass_cnt++;
			$display("%s passed", name);
		end else begin
			fail_cnt++;
			$display("%s failed", name);
		end
		test_errs = err_cnt;
	endtask

	function automatic logic [7:0] random_byte();
		logic [31:0] rnd;
		rnd = $random(seed);
		return rnd[7:0];
	endfunction

	// one-cycle strobe, returns on the edge that drops it
	task automatic send_cmd(input spi_cmd_pkg::cmd_op_e op, input logic [7:0] data);
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd <= {op, data};
		@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	task automatic load_slave(input logic [7:0] b);
		@(posedge clk);
		slave_byte <= b;
		@(posedge clk);
		slave_load <= 1'b1;
		@(posedge clk);
		slave_load <= 1'b0;
	endtask

	task automatic run_xfer(input string name, input int n_drop);
		logic [7:0] tx;
		logic [7:0] rx;
		logic [31:0] rnd;
		logic got;
		logic prev_dclk;
		logic seen_fall;
		int cycles;
		int run;
		tx = random_byte();
		rx = random_byte();
		load_slave(rx);
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd <= {spi_cmd_pkg::OP_XFER, tx};
		cycles = 0;
		run = 0;
		got = 1'b0;
		prev_dclk = 1'b0;
		seen_fall = 1'b0;
		while (!got && cycles < XFER_LIMIT) begin
			@(posedge clk);
			cycles++;
			if (cycles % 2 == 0 && cycles <= 2 * n_drop) begin
				cmd_valid <= 1'b1; // lands while busy
				rnd = $random(seed);
				if (cycles == 2)
					cmd <= {spi_cmd_pkg::OP_CS, 7'd0, ~model_cs_n};
				else if (cycles == 4)
					cmd <= {spi_cmd_pkg::OP_DIV, 8'(model_div % 4 + 1)};
				else
					cmd <= rnd[spi_cmd_pkg::CMD_W-1:0];
			end else begin
				cmd_valid <= 1'b0;
			end
			@(negedge clk);
			// half lengths at the pin, the first low half includes the load cycle
			if (dclk !== prev_dclk) begin
				if (prev_dclk) begin
					compare($sformatf("%s dclk high", name), model_div, run);
					seen_fall = 1'b1;
				end else if (seen_fall) begin
					compare($sformatf("%s dclk low", name), model_div, run);
				end
				prev_dclk = dclk;
				run = 1;
			end else begin
				run++;
			end
			// high from the cycle after the strobe until the cycle after done
			compare($sformatf("%s busy level", name), cycles < 4 + 16 * model_div, busy);
			got = rsp_valid;
		end
		if (!got) begin
			$display("%s: no response within %0d cycles", name, XFER_LIMIT);
			err_cnt++;
		end else begin
			model_xfers++;
			model_drops += n_drop;
			compare($sformatf("%s latency", name), 4 + 16 * model_div, cycles);
			compare($sformatf("%s rsp_data", name), rx, rsp_data);
			compare($sformatf("%s slave_rx", name), tx, slave_rx);
		end
		@(negedge clk);
		compare($sformatf("%s rsp_valid low", name), 0, rsp_valid); // single strobe
		compare($sformatf("%s busy", name), 0, busy);
		compare($sformatf("%s cs_n", name), model_cs_n, cs_n);
		compare($sformatf("%s xfer_count", name), model_xfers % 256, xfer_count);
		compare($sformatf("%s drop_count", name), model_drops % 256, drop_count);
		finish_test(name);
	endtask

	// watchdog
	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", RUN_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		logic [7:0] d;
		int r;
		seed = 32'h1828_4584;
		err_cnt = 0;
		test_errs = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		slave_load = 1'b0;
		slave_byte = '0;
		model_cs_n = 1'b1;
		model_div = 1;
		model_xfers = 0;
		model_drops = 0;

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		compare("reset cs_n", 1, cs_n);
		compare("reset dclk", 0, dclk);
		compare("reset mosi", 0, mosi);
		compare("reset busy", 0, busy);
		compare("reset rsp_valid", 0, rsp_valid);
		compare("reset xfer_count", 0, xfer_count);
		compare("reset drop_count", 0, drop_count);
		finish_test("reset");

		for (int i = 0; i < N_CS; i++) begin
			d = random_byte();
			send_cmd(spi_cmd_pkg::OP_CS, d);
			@(negedge clk);
			model_cs_n = d[0];
			compare($sformatf("cs%0d level", i), model_cs_n, cs_n);
			finish_test($sformatf("cs%0d", i));
		end

		for (int i = 0; i < N_XFER; i++) begin
			r = (i == 0) ? 0 : {$random(seed)} % 5; // zero means 1
			send_cmd(spi_cmd_pkg::OP_DIV, r[7:0]);
			model_div = (r == 0) ? 1 : r;
			if (i % 4 == 3) begin
				d = random_byte();
				send_cmd(spi_cmd_pkg::OP_CS, d);
				model_cs_n = d[0];
			end
			r = {$random(seed)} % 4;
			run_xfer($sformatf("xfer%0d", i), r);
		end

		@(negedge clk);
		compare("final xfer_count", model_xfers % 256, xfer_count);
		compare("final drop_count", model_drops % 256, drop_count);
		finish_test("counts");

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (err_cnt == 0 && fail_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: tb_spi_slave.sv
`timescale 1ns/1ps

module tb_spi_slave (
	input  logic i_dclk,
	input  logic i_mosi,
	input  logic i_load,
	input  logic [7:0] i_load_byte,
	output logic o_miso,
	output logic [7:0] o_rx_byte
);

	logic [7:0] tx_sr = '0;
	logic [7:0] rx_sr = '0;

	// load only while the bus is idle
	always @(posedge i_load or negedge i_dclk) begin
		if (i_load)
			tx_sr <= i_load_byte;
		else
			tx_sr <= {tx_sr[6:0], 1'b0}; // next bit on falling dclk
	end

	// mosi does not move across the rising edge
	always @(posedge i_dclk) begin
		rx_sr <= {rx_sr[6:0], i_mosi};
	end

	assign o_miso = tx_sr[7];
	assign o_rx_byte = rx_sr;

endmodule

// File: spi_cmd_ctrl.sv
`timescale 1ns/1ps

module spi_cmd_ctrl #(
	parameter int DIV_W = 16,
	parameter int CNT_W = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_cmd_valid,
	input  logic [spi_cmd_pkg::CMD_W-1:0] i_cmd,
	output logic o_busy,
	output logic o_rsp_valid,
	output logic [spi_cmd_pkg::CMD_DATA_W-1:0] o_rsp_data,
	output logic [CNT_W-1:0] o_xfer_count,
	output logic [CNT_W-1:0] o_drop_count,
	output logic o_spi_cs_n,
	output logic o_spi_dclk,
	output logic o_spi_mosi,
	input  logic i_spi_miso
);

	// transfer width follows the data field of the command word
	localparam int DATA_W = spi_cmd_pkg::CMD_DATA_W;

	logic drop;

	spi_xfer_if #(
		.DATA_W(DATA_W),
		.DIV_W (DIV_W)
	) xfer_if ();

	spi_cmd_decode #(
		.DIV_W(DIV_W)
	) u_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_cmd_valid(i_cmd_valid),
		.i_cmd      (i_cmd),
		.o_spi_cs_n (o_spi_cs_n),
		.o_busy     (o_busy),
		.o_drop     (drop),
		.xfer       (xfer_if)
	);

	spi_byte_engine #(
		.DATA_W(DATA_W),
		.DIV_W (DIV_W)
	) u_engine (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_spi_miso(i_spi_miso),
		.o_spi_dclk(o_spi_dclk),
		.o_spi_mosi(o_spi_mosi),
		.xfer      (xfer_if)
	);

	spi_rsp_collect #(
		.DATA_W(DATA_W),
		.CNT_W (CNT_W)
	) u_collect (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_drop      (drop),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp_data  (o_rsp_data),
		.o_xfer_count(o_xfer_count),
		.o_drop_count(o_drop_count),
		.xfer        (xfer_if)
	);

endmodule

// File: spi_rsp_collect.sv
`timescale 1ns/1ps

module spi_rsp_collect #(
	parameter int DATA_W = 8,
	parameter int CNT_W = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_drop,
	output logic o_rsp_valid,
	output logic [DATA_W-1:0] o_rsp_data,
	output logic [CNT_W-1:0] o_xfer_count,
	output logic [CNT_W-1:0] o_drop_count,
	spi_xfer_if.result xfer
);

	logic rsp_valid_q;
	logic [DATA_W-1:0] rsp_data_q;
	logic [CNT_W-1:0] xfer_cnt;
	logic [CNT_W-1:0] drop_cnt;

	// strobe one cycle after done, not held
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rsp_valid_q <= 1'b0;
		else
			rsp_valid_q <= xfer.done;
	end

	always_ff @(posedge clk) begin
		if (xfer.done)
			rsp_data_q <= xfer.rx_byte;
	end

	// both counters wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xfer_cnt <= '0;
			drop_cnt <= '0;
		end else begin
			if (xfer.done)
				xfer_cnt <= xfer_cnt + CNT_W'(1);
			if (i_drop)
				drop_cnt <= drop_cnt + CNT_W'(1);
		end
	end

	assign o_rsp_valid = rsp_valid_q;
	assign o_rsp_data = rsp_data_q;
	assign o_xfer_count = xfer_cnt;
	assign o_drop_count = drop_cnt;

endmodule

// File: spi_byte_engine.sv
`timescale 1ns/1ps

module spi_byte_engine #(
	parameter int DATA_W = 8,
	parameter int DIV_W = 16
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_spi_miso,
	output logic o_spi_dclk,
	output logic o_spi_mosi,
	spi_xfer_if.engine xfer
);

	localparam int BIT_W = $clog2(DATA_W + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_LOW,
		ST_HIGH,
		ST_FINISH
	} state_e;

	state_e state;
	logic [DIV_W-1:0] half_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic [DATA_W-1:0] tx_sr;
	logic [DATA_W-1:0] rx_sr;
	logic dclk_q;
	logic half_end;
	logic last_bit;

	assign half_end = (half_cnt == xfer.clk_div - DIV_W'(1));
	assign last_bit = (bit_cnt == BIT_W'(DATA_W - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (xfer.start)
						state <= ST_LOAD;
				end
				ST_LOAD: begin
					state <= ST_LOW;
				end
				ST_LOW: begin
					if (half_end)
						state <= ST_HIGH;
				end
				ST_HIGH: begin
					if (half_end)
						state <= last_bit ? ST_FINISH : ST_LOW;
				end
				ST_FINISH: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// half-period counter, clk_div cycles per half
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			half_cnt <= '0;
		else if ((state == ST_LOW || state == ST_HIGH) && !half_end)
			half_cnt <= half_cnt + DIV_W'(1);
		else
			half_cnt <= '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bit_cnt <= '0;
		else if (state == ST_LOAD)
			bit_cnt <= '0;
		else if (state == ST_HIGH && half_end)
			bit_cnt <= bit_cnt + BIT_W'(1);
	end

	// dclk follows the state, rises after the low half and falls after the high half
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dclk_q <= 1'b0;
		else if (state == ST_LOW && half_end)
			dclk_q <= 1'b1;
		else if (state == ST_HIGH && half_end)
			dclk_q <= 1'b0;
	end

	// zeros shift in behind the data, so mosi idles low
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			tx_sr <= '0;
		else if (state == ST_LOAD)
			tx_sr <= xfer.tx_byte;
		else if (state == ST_HIGH && half_end)
			tx_sr <= tx_sr << 1; // next bit with the falling edge
	end

	// sample where dclk rises, first bit ends up in the msb
	always_ff @(posedge clk) begin
		if (state == ST_LOW && half_end)
			rx_sr <= {rx_sr[DATA_W-2:0], i_spi_miso};
	end

	assign o_spi_dclk = dclk_q;
	assign o_spi_mosi = tx_sr[DATA_W-1];

	assign xfer.done = (state == ST_FINISH);
	assign xfer.rx_byte = rx_sr;

endmodule

// File: spi_cmd_decode.sv
`timescale 1ns/1ps

module spi_cmd_decode #(
	parameter int DIV_W = 16
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_cmd_valid,
	input  logic [spi_cmd_pkg::CMD_W-1:0] i_cmd,
	output logic o_spi_cs_n,
	output logic o_busy,
	output logic o_drop,
	spi_xfer_if.decode xfer
);

	spi_cmd_pkg::cmd_op_e cmd_op;
	logic [spi_cmd_pkg::CMD_DATA_W-1:0] cmd_data;
	logic accept;
	logic accept_xfer;

	logic cs_n_q;
	logic busy_q;
	logic start_q;
	logic drop_q;
	logic [DIV_W-1:0] div_q;
	logic [spi_cmd_pkg::CMD_DATA_W-1:0] tx_q;

	// split the command word
	assign cmd_op = spi_cmd_pkg::cmd_op_e'(i_cmd[spi_cmd_pkg::OP_LSB +: spi_cmd_pkg::OP_W]);
	assign cmd_data = i_cmd[spi_cmd_pkg::DATA_LSB +: spi_cmd_pkg::CMD_DATA_W];

	// nothing is queued, so a command is taken only while idle
	assign accept = i_cmd_valid && !busy_q;
	assign accept_xfer = accept && (cmd_op == spi_cmd_pkg::OP_XFER);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cs_n_q <= 1'b1;
			div_q <= DIV_W'(1);
			busy_q <= 1'b0;
			start_q <= 1'b0;
			drop_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			drop_q <= 1'b0;
			if (busy_q) begin
				if (xfer.done)
					busy_q <= 1'b0; // low from the cycle after done
				if (i_cmd_valid)
					drop_q <= 1'b1;
			end else if (accept) begin
				case (cmd_op)
					spi_cmd_pkg::OP_CS: begin
						cs_n_q <= cmd_data[spi_cmd_pkg::CS_BIT];
					end
					spi_cmd_pkg::OP_DIV: begin
						if (cmd_data == '0)
							div_q <= DIV_W'(1);
						else
							div_q <= DIV_W'(cmd_data);
					end
					spi_cmd_pkg::OP_XFER: begin
						start_q <= 1'b1;
						busy_q <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// byte to send, held by busy until done
	always_ff @(posedge clk) begin
		if (accept_xfer)
			tx_q <= cmd_data;
	end

	assign xfer.start = start_q;
	assign xfer.tx_byte = tx_q;
	assign xfer.clk_div = div_q;

	assign o_spi_cs_n = cs_n_q;
	assign o_busy = busy_q;
	assign o_drop = drop_q;

endmodule

// File: spi_xfer_if.sv
`timescale 1ns/1ps

interface spi_xfer_if #(
	parameter int DATA_W = 8,
	parameter int DIV_W = 16
);

	logic start;                // one cycle, only while decoder is idle
	logic [DATA_W-1:0] tx_byte; // held from start until done
	logic [DIV_W-1:0] clk_div;  // half-period length in clk cycles
	logic done;                 // one cycle per start
	logic [DATA_W-1:0] rx_byte; // valid while done is high

	modport decode (
		output start,
		output tx_byte,
		output clk_div,
		input  done
	);

	modport engine (
		input  start,
		input  tx_byte,
		input  clk_div,
		output done,
		output rx_byte
	);

	modport result (
		input done,
		input rx_byte
	);

endinterface

// File: spi_cmd_pkg.sv
package spi_cmd_pkg;

	// host command word, opcode on top and data byte below
	parameter int CMD_W = 10;
	parameter int OP_W = 2;
	parameter int CMD_DATA_W = 8;

	// field positions inside the command word
	parameter int OP_LSB = CMD_W - OP_W;
	parameter int DATA_LSB = 0;

	// chip-select level bit inside the data byte of OP_CS
	parameter int CS_BIT = 0;

	// OP_NOP   does nothing
	// OP_CS    loads the active-low chip-select from data bit CS_BIT
	// OP_DIV   loads the half-period divider, a zero byte is stored as 1
	// OP_XFER  shifts the data byte out and one byte back in
	typedef enum logic [OP_W-1:0] {
		OP_NOP  = 2'd0,
		OP_CS   = 2'd1,
		OP_DIV  = 2'd2,
		OP_XFER = 2'd3
	} cmd_op_e;

endpackage
